//--- Makefile
VERILATOR ?= verilator
TOP       ?= exe_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hdl/exe_pkg.sv
hdl/alu.sv
hdl/div_ctrl.sv
hdl/div_counter.sv
hdl/div_datapath.sv
hdl/lsu_req.sv
hdl/exe_stage.sv
verif/exe_checker.sv
verif/exe_tb.sv

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  exe_pkg::alu_op_t alu_op,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result
);
    import exe_pkg::*;

    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;

    // shift amount comes from the low bits only
    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    always_comb begin
        case (alu_op)
            op_add: begin
                result = sum;
            end
            op_sub: begin
                result = diff;
            end
            op_slt: begin
                result = {31'd0, $signed(src1) < $signed(src2)};
            end
            op_sltu: begin
                result = {31'd0, src1 < src2};
            end
            op_and: begin
                result = src1 & src2;
            end
            op_or: begin
                result = src1 | src2;
            end
            op_xor: begin
                result = src1 ^ src2;
            end
            op_nor: begin
                result = ~(src1 | src2);
            end
            op_sll: begin
                result = src1 << shamt;
            end
            op_srl: begin
                result = src1 >> shamt;
            end
            op_sra: begin
                result = word_t'($signed(src1) >>> shamt);
            end
            op_lui: begin
                // immediate already shifted by decode
                result = src2;
            end
            default: begin
                // divider ops are resolved in the stage
                result = '0;
            end
        endcase
    end

endmodule

//--- hdl/div_counter.sv
`timescale 1ns/1ps

module div_counter (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  logic step,
    output logic last
);
    import exe_pkg::*;

    logic [4:0] count;

    assign last = step && (count == 5'(div_steps - 1));

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (step) begin
            // wraps back to zero after the final step
            count <= count + 5'd1;
        end
    end

endmodule

//--- hdl/div_ctrl.sv
`timescale 1ns/1ps

module div_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic flush,
    input  logic leave,
    input  logic last,
    output logic step,
    output logic load,
    output logic done
);
    import exe_pkg::*;

    div_state_t state;

    assign load = (state == div_idle) && start && !flush;
    assign step = (state == div_busy) && !flush;
    assign done = (state == div_done);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= div_idle;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state <= div_busy;
                    end
                end
                div_busy: begin
                    // last step is taken on this edge
                    if (last) begin
                        state <= div_done;
                    end
                end
                div_done: begin
                    if (leave) begin
                        state <= div_idle;
                    end
                end
                default: begin
                    state <= div_idle;
                end
            endcase
        end
    end

endmodule

//--- hdl/div_datapath.sv
`timescale 1ns/1ps

module div_datapath (
    input  logic           clk,
    input  logic           load,
    input  logic           step,
    input  exe_pkg::word_t dividend,
    input  exe_pkg::word_t divisor,
    output exe_pkg::word_t quotient,
    output exe_pkg::word_t remainder
);
    import exe_pkg::*;

    word_t       rem_q;
    word_t       quo_q;
    logic [32:0] rem_shift;
    logic [32:0] trial;
    logic        fits;

    // bring in the next dividend bit from the top of the quotient register
    assign rem_shift = {rem_q, quo_q[31]};
    assign trial     = rem_shift - {1'b0, divisor};
    // no borrow means the divisor fits
    assign fits      = !trial[32];

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q <= '0;
            quo_q <= dividend;
        end else if (step) begin
            if (fits) begin
                rem_q <= trial[31:0];
            end else begin
                rem_q <= rem_shift[31:0];
            end
            quo_q <= {quo_q[30:0], fits};
        end
    end

    // a zero divisor always fits, so the quotient fills with ones
    // and the remainder ends up holding the dividend
    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

//--- hdl/exe_pkg.sv
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [15:0] excp_t;

    // alu operation codes
    localparam alu_op_t op_add  = 4'd0;
    localparam alu_op_t op_sub  = 4'd1;
    localparam alu_op_t op_slt  = 4'd2;
    localparam alu_op_t op_sltu = 4'd3;
    localparam alu_op_t op_and  = 4'd4;
    localparam alu_op_t op_or   = 4'd5;
    localparam alu_op_t op_xor  = 4'd6;
    localparam alu_op_t op_nor  = 4'd7;
    localparam alu_op_t op_sll  = 4'd8;
    localparam alu_op_t op_srl  = 4'd9;
    localparam alu_op_t op_sra  = 4'd10;
    localparam alu_op_t op_lui  = 4'd11;
    localparam alu_op_t op_divu = 4'd12;
    localparam alu_op_t op_modu = 4'd13;

    // access sizes
    localparam mem_size_t size_byte = 2'd0;
    localparam mem_size_t size_half = 2'd1;
    localparam mem_size_t size_word = 2'd2;

    // address error on load or store
    localparam int excp_ale_bit = 6;

    localparam int div_steps = 32;

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_t;

    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rj_value;
        word_t     rkd_value;
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_4;
        logic      mem_en;
        logic      mem_we;
        mem_size_t mem_size;
        logic      load_unsigned;
        reg_idx_t  dest;
        logic      gr_we;
        logic      excp;
        excp_t     excp_num;
    } ds_to_es_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_idx_t  dest;
        logic      gr_we;
        logic      res_from_mem;
        logic      load_unsigned;
        mem_size_t mem_size;
        logic [1:0] addr_low;
        logic      excp;
        excp_t     excp_num;
    } es_to_ms_t;

    typedef struct packed {
        logic     valid;
        logic     gr_we;
        reg_idx_t dest;
        word_t    result;
        logic     is_load;
    } es_forward_t;

    typedef struct packed {
        logic       en;
        logic [3:0] wstrb;
        word_t      addr;
        word_t      wdata;
        mem_size_t  size;
    } mem_req_t;

endpackage

//--- hdl/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ds_to_es_valid,
    input  exe_pkg::ds_to_es_t  ds_to_es_bus,
    output logic                es_allowin,
    output logic                es_to_ms_valid,
    output exe_pkg::es_to_ms_t  es_to_ms_bus,
    input  logic                ms_allowin,
    output exe_pkg::es_forward_t es_forward,
    output exe_pkg::mem_req_t   mem_req,
    input  logic                data_sram_addr_ok,
    input  logic                excp_flush,
    input  logic                ertn_flush
);
    import exe_pkg::*;

    ds_to_es_t ds_r;
    logic      es_valid;
    logic      req_done;
    logic      es_ready_go;
    logic      es_leave;
    logic      flush;

    word_t      alu_src1;
    word_t      alu_src2;
    word_t      alu_result;
    word_t      es_result;
    word_t      quotient;
    word_t      remainder;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       misaligned;
    logic       ale;
    logic       es_excp;
    excp_t      es_excp_num;
    logic       is_div;
    logic       is_load;
    logic       mem_en;

    logic div_step;
    logic div_load;
    logic div_done;
    logic div_last;

    assign flush = excp_flush | ertn_flush;

    // handshake
    assign es_to_ms_valid = es_valid && es_ready_go && !flush;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_leave       = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            ds_r <= ds_to_es_bus;
        end
    end

    // operand select
    assign alu_src1 = ds_r.src1_is_pc ? ds_r.pc : ds_r.rj_value;
    assign alu_src2 = ds_r.src2_is_4   ? 32'd4 :
                      ds_r.src2_is_imm ? ds_r.imm : ds_r.rkd_value;

    alu u_alu (
        .alu_op (ds_r.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign is_div = (ds_r.alu_op == op_divu) || (ds_r.alu_op == op_modu);

    div_ctrl u_div_ctrl (
        .clk   (clk),
        .reset (reset),
        .start (es_valid && is_div && !ds_r.excp),
        .flush (flush),
        .leave (es_leave),
        .last  (div_last),
        .step  (div_step),
        .load  (div_load),
        .done  (div_done)
    );

    div_counter u_div_counter (
        .clk   (clk),
        .reset (reset),
        .clear (div_load),
        .step  (div_step),
        .last  (div_last)
    );

    div_datapath u_div_datapath (
        .clk       (clk),
        .load      (div_load),
        .step      (div_step),
        .dividend  (alu_src1),
        .divisor   (alu_src2),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign es_result = !is_div ? alu_result :
                       (ds_r.alu_op == op_modu) ? remainder : quotient;

    // address comes from the adder
    lsu_req u_lsu_req (
        .addr       (alu_result),
        .store_data (ds_r.rkd_value),
        .size       (ds_r.mem_size),
        .mem_we     (ds_r.mem_we),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .misaligned (misaligned)
    );

    assign ale     = ds_r.mem_en && misaligned;
    assign es_excp = ds_r.excp || ale;
    assign is_load = ds_r.mem_en && !ds_r.mem_we;

    always_comb begin
        es_excp_num = ds_r.excp_num;
        es_excp_num[excp_ale_bit] = ds_r.excp_num[excp_ale_bit] | ale;
    end

    assign mem_en = es_valid && ds_r.mem_en && !es_excp && !flush && !req_done;

    // held high once accepted so the request is not issued twice
    always_ff @(posedge clk) begin
        if (reset || flush || es_leave) begin
            req_done <= 1'b0;
        end else if (mem_en && data_sram_addr_ok) begin
            req_done <= 1'b1;
        end
    end

    always_comb begin
        if (es_excp) begin
            es_ready_go = 1'b1;
        end else if (is_div) begin
            es_ready_go = div_done;
        end else if (ds_r.mem_en) begin
            es_ready_go = req_done || (mem_en && data_sram_addr_ok);
        end else begin
            es_ready_go = 1'b1;
        end
    end

    always_comb begin
        mem_req.en    = mem_en;
        mem_req.wstrb = wstrb;
        mem_req.addr  = alu_result;
        mem_req.wdata = wdata;
        mem_req.size  = ds_r.mem_size;
    end

    always_comb begin
        es_to_ms_bus.pc            = ds_r.pc;
        es_to_ms_bus.result        = es_result;
        es_to_ms_bus.dest          = ds_r.dest;
        es_to_ms_bus.gr_we         = ds_r.gr_we;
        es_to_ms_bus.res_from_mem  = is_load;
        es_to_ms_bus.load_unsigned = ds_r.load_unsigned;
        es_to_ms_bus.mem_size      = ds_r.mem_size;
        es_to_ms_bus.addr_low      = alu_result[1:0];
        es_to_ms_bus.excp          = es_excp;
        es_to_ms_bus.excp_num      = es_excp_num;
    end

    // decode uses is_load to stall on a load-use hazard
    always_comb begin
        es_forward.valid   = es_valid;
        es_forward.gr_we   = ds_r.gr_we;
        es_forward.dest    = ds_r.dest;
        es_forward.result  = es_result;
        es_forward.is_load = is_load;
    end

endmodule

//--- hdl/lsu_req.sv
`timescale 1ns/1ps

module lsu_req (
    input  exe_pkg::word_t     addr,
    input  exe_pkg::word_t     store_data,
    input  exe_pkg::mem_size_t size,
    input  logic               mem_we,
    output logic [3:0]         wstrb,
    output exe_pkg::word_t     wdata,
    output logic               misaligned
);
    import exe_pkg::*;

    logic [3:0] strb;

    always_comb begin
        case (size)
            size_byte: begin
                strb = 4'b0001 << addr[1:0];
            end
            size_half: begin
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                strb = 4'b1111;
            end
        endcase
    end

    // loads never write
    assign wstrb = mem_we ? strb : 4'b0000;

    always_comb begin
        case (size)
            size_byte: begin
                wdata = {4{store_data[7:0]}};
            end
            size_half: begin
                wdata = {2{store_data[15:0]}};
            end
            default: begin
                wdata = store_data;
            end
        endcase
    end

    always_comb begin
        misaligned = 1'b0;
        if (size == size_half) begin
            misaligned = addr[0];
        end else if (size == size_word) begin
            misaligned = |addr[1:0];
        end
    end

endmodule

//--- verif/exe_checker.sv
`timescale 1ns/1ps

module exe_checker (
    input logic                clk,
    input logic                reset,
    input logic                es_valid,
    input logic                es_to_ms_valid,
    input logic                ms_allowin,
    input logic                excp_flush,
    input logic                ertn_flush,
    input exe_pkg::es_to_ms_t  es_to_ms_bus,
    input exe_pkg::mem_req_t   mem_req
);

    // a stalled record holds until the memory stage takes it
    stall_stable: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> $stable(es_to_ms_bus))
        else $error("es_to_ms_bus changed while stalled");

    excp_no_req: assert property (@(posedge clk) disable iff (reset)
        es_valid && es_to_ms_bus.excp |-> !mem_req.en)
        else $error("memory request issued for an excepting instruction");

    // no acceptance can happen in a flush cycle, so the stage is empty next
    flush_empties: assert property (@(posedge clk) disable iff (reset)
        (excp_flush || ertn_flush) |=> !es_to_ms_valid)
        else $error("output valid in the cycle after a flush");

endmodule

bind exe_stage exe_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .es_valid       (es_valid),
    .es_to_ms_valid (es_to_ms_valid),
    .ms_allowin     (ms_allowin),
    .excp_flush     (excp_flush),
    .ertn_flush     (ertn_flush),
    .es_to_ms_bus   (es_to_ms_bus),
    .mem_req        (mem_req)
);

//--- verif/exe_tb.sv
`timescale 1ns/1ps

module exe_tb;
    import exe_pkg::*;

    localparam int total_instr    = 304;
    localparam int timeout_cycles = total_instr * 40 + 2000;
    // valid in the cycle before the edge 34 cycles after acceptance
    localparam int div_ready_age  = div_steps + 2;

    typedef struct {
        es_to_ms_t rec;
        mem_req_t  req;
        logic      needs_req;
        logic      is_mem;
        logic      is_div;
        int        accepted;
        int        age;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es_bus;
    logic        es_allowin;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    logic        ms_allowin;
    es_forward_t es_forward;
    mem_req_t    mem_req;
    logic        data_sram_addr_ok;
    logic        excp_flush;
    logic        ertn_flush;

    logic [31:0] lfsr;
    expect_t     pending[$];
    expect_t     offer;
    int          n_checks;
    int          n_errors;
    int          issued;
    // mix of the running test, weights out of 8
    int          cfg_div;
    int          cfg_mem;
    int          cfg_excp;
    int          cfg_align;
    bit          cfg_bp;
    bit          cfg_flush;

    exe_stage dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic word_t draw(int nbits);
        word_t v = '0;
        for (int i = 0; i < nbits; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return word_t'({{32{a[31]}}, a} >> b[4:0]);
            op_lui:  return b;
            // divide by zero gives all ones, remainder keeps the dividend
            op_divu: return (b == 0) ? 32'hffff_ffff : a / b;
            op_modu: return (b == 0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    task automatic check(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic build_instr(output ds_to_es_t d, output expect_t e);
        int         kind;
        logic [11:0] imm12;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       mis;
        d = '0;
        d.pc = draw(30) << 2;
        d.rj_value = draw(32);
        d.rkd_value = draw(32);
        d.imm = draw(32);
        d.dest = reg_idx_t'(draw(5));
        d.gr_we = draw(1) != 0;
        kind = int'(draw(3));
        if (kind < cfg_mem) begin
            d.mem_en = 1'b1;
            d.mem_we = draw(1) != 0;
            d.mem_size = mem_size_t'(draw(2) % 3);
            d.load_unsigned = draw(1) != 0;
            d.alu_op = op_add;
            d.src2_is_imm = 1'b1;
            imm12 = 12'(draw(12));
            d.imm = {{20{imm12[11]}}, imm12};
            d.gr_we = !d.mem_we;
            if (int'(draw(3)) < cfg_align) begin
                d.rj_value[1:0] = 2'b00;
                d.imm[1:0] = 2'b00;
            end
        end else if (kind < cfg_mem + cfg_div) begin
            d.alu_op = (draw(1) != 0) ? op_modu : op_divu;
            d.rkd_value = (draw(3) == 0) ? '0 : d.rkd_value >> draw(5);
        end else begin
            d.alu_op = alu_op_t'(draw(4) % 12);
            d.src1_is_pc = draw(1) != 0;
            d.src2_is_imm = draw(1) != 0;
            d.src2_is_4 = draw(2) == 0;
        end
        if (d.alu_op != op_divu && d.alu_op != op_modu && int'(draw(3)) < cfg_excp) begin
            d.excp = 1'b1;
            d.excp_num = excp_t'(draw(16));
        end

        a = d.src1_is_pc ? d.pc : d.rj_value;
        b = d.src2_is_4 ? 32'd4 : (d.src2_is_imm ? d.imm : d.rkd_value);
        res = model_alu(d.alu_op, a, b);
        mis = d.mem_en && ((d.mem_size == size_half && res[0]) ||
                           (d.mem_size == size_word && res[1:0] != 2'b00));
        e.rec = '0;
        e.rec.pc = d.pc;
        e.rec.result = res;
        e.rec.dest = d.dest;
        e.rec.gr_we = d.gr_we;
        e.rec.res_from_mem = d.mem_en && !d.mem_we;
        e.rec.load_unsigned = d.load_unsigned;
        e.rec.mem_size = d.mem_size;
        e.rec.addr_low = res[1:0];
        e.rec.excp = d.excp || mis;
        e.rec.excp_num = d.excp_num;
        e.rec.excp_num[excp_ale_bit] = d.excp_num[excp_ale_bit] | mis;

        e.req = '0;
        e.req.en = 1'b1;
        e.req.addr = res;
        e.req.size = d.mem_size;
        case (d.mem_size)
            size_byte: begin
                e.req.wstrb[res[1:0]] = 1'b1;
                e.req.wdata = {4{d.rkd_value[7:0]}};
            end
            size_half: begin
                e.req.wstrb = res[1] ? 4'b1100 : 4'b0011;
                e.req.wdata = {2{d.rkd_value[15:0]}};
            end
            default: begin
                e.req.wstrb = 4'b1111;
                e.req.wdata = d.rkd_value;
            end
        endcase
        if (!d.mem_we) begin
            e.req.wstrb = 4'b0000;
        end
        e.needs_req = d.mem_en && !e.rec.excp;
        e.is_mem = d.mem_en;
        e.is_div = (d.alu_op == op_divu) || (d.alu_op == op_modu);
        e.accepted = 0;
        e.age = 0;
    endtask

    task automatic drive(input bit issue);
        ds_to_es_t d;
        build_instr(d, offer);
        ds_to_es_bus = d;
        ds_to_es_valid = issue && (draw(2) != 0);
        ms_allowin = !cfg_bp || (draw(2) != 0);
        data_sram_addr_ok = !cfg_bp || (draw(2) != 0);
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        if (cfg_flush && draw(5) == 0) begin
            if (draw(1) != 0) begin
                excp_flush = 1'b1;
            end else begin
                ertn_flush = 1'b1;
            end
        end
    endtask

    task automatic compare_record(input expect_t e);
        check("pc", es_to_ms_bus.pc, e.rec.pc);
        check("result", es_to_ms_bus.result, e.rec.result);
        check("dest", 32'(es_to_ms_bus.dest), 32'(e.rec.dest));
        check("gr_we", 32'(es_to_ms_bus.gr_we), 32'(e.rec.gr_we));
        check("res_from_mem", 32'(es_to_ms_bus.res_from_mem), 32'(e.rec.res_from_mem));
        check("load_unsigned", 32'(es_to_ms_bus.load_unsigned), 32'(e.rec.load_unsigned));
        check("mem_size", 32'(es_to_ms_bus.mem_size), 32'(e.rec.mem_size));
        if (e.is_mem) begin
            check("addr_low", 32'(es_to_ms_bus.addr_low), 32'(e.rec.addr_low));
        end
        check("excp", 32'(es_to_ms_bus.excp), 32'(e.rec.excp));
        check("excp_num", 32'(es_to_ms_bus.excp_num), 32'(e.rec.excp_num));
        // each memory op is accepted exactly once
        check("request count", e.accepted, e.needs_req ? 32'd1 : 32'd0);
    endtask

    task automatic observe();
        logic f;
        logic exp_en;
        logic exp_valid;
        logic exp_allowin;
        f = excp_flush || ertn_flush;
        foreach (pending[i]) begin
            pending[i].age = pending[i].age + 1;
        end
        exp_en = 1'b0;
        exp_valid = 1'b0;
        check("forward valid", 32'(es_forward.valid), 32'(pending.size() != 0));
        if (pending.size() != 0) begin
            check("forward dest", 32'(es_forward.dest), 32'(pending[0].rec.dest));
            check("forward gr_we", 32'(es_forward.gr_we), 32'(pending[0].rec.gr_we));
            check("forward is_load", 32'(es_forward.is_load),
                  32'(pending[0].rec.res_from_mem));
            exp_en = pending[0].needs_req && pending[0].accepted == 0 && !f;
            if (f) begin
                exp_valid = 1'b0;
            end else if (pending[0].rec.excp) begin
                exp_valid = 1'b1;
            end else if (pending[0].is_div) begin
                exp_valid = pending[0].age >= div_ready_age;
            end else if (pending[0].is_mem) begin
                exp_valid = pending[0].accepted != 0 || data_sram_addr_ok;
            end else begin
                exp_valid = 1'b1;
            end
        end
        exp_allowin = (pending.size() == 0) || (exp_valid && ms_allowin);
        check("memory request enable", 32'(mem_req.en), 32'(exp_en));
        check("output valid", 32'(es_to_ms_valid), 32'(exp_valid));
        // during a flush the stage is discarded whatever allowin shows
        if (!f) begin
            check("input allowin", 32'(es_allowin), 32'(exp_allowin));
        end
        if (mem_req.en && data_sram_addr_ok && pending.size() != 0) begin
            check("request addr", mem_req.addr, pending[0].req.addr);
            check("request size", 32'(mem_req.size), 32'(pending[0].req.size));
            check("request wstrb", 32'(mem_req.wstrb), 32'(pending[0].req.wstrb));
            check("request wdata", mem_req.wdata, pending[0].req.wdata);
            pending[0].accepted = pending[0].accepted + 1;
        end
        if (es_to_ms_valid && pending.size() != 0) begin
            check("forward result", es_forward.result, pending[0].rec.result);
            if (ms_allowin) begin
                compare_record(pending[0]);
                void'(pending.pop_front());
            end
        end
        if (f) begin
            pending.delete();
        end
        if (ds_to_es_valid && exp_allowin && !f) begin
            pending.push_back(offer);
            issued++;
        end
    endtask

    task automatic run_test(input string name, input int n, input int div_w,
                            input int mem_w, input int excp_w, input int align_w,
                            input bit bp, input bit flush_en);
        int err0;
        err0 = n_errors;
        issued = 0;
        cfg_div = div_w;
        cfg_mem = mem_w;
        cfg_excp = excp_w;
        cfg_align = align_w;
        cfg_bp = bp;
        cfg_flush = flush_en;
        while (issued < n) begin
            @(posedge clk);
            #1;
            drive(1'b1);
            @(negedge clk);
            observe();
        end
        // let the stage empty before the next test
        while (pending.size() != 0) begin
            @(posedge clk);
            #1;
            drive(1'b0);
            @(negedge clk);
            observe();
        end
        $display("test %s: %0d instructions, %0d errors", name, n, n_errors - err0);
    endtask

    initial begin
        #(timeout_cycles * 10);
        $display("timeout: the run did not finish in %0d cycles", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        lfsr = 32'he4d1;
        n_checks = 0;
        n_errors = 0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus = '0;
        ms_allowin = 1'b1;
        data_sram_addr_ok = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        run_test("alu_ops", 60, 0, 0, 0, 8, 1'b0, 1'b0);
        run_test("divide", 24, 4, 0, 0, 8, 1'b0, 1'b0);
        run_test("load_store", 40, 0, 8, 0, 8, 1'b0, 1'b0);
        run_test("misaligned", 40, 0, 8, 2, 2, 1'b0, 1'b0);
        run_test("backpressure", 80, 2, 3, 1, 6, 1'b1, 1'b0);
        run_test("flush", 60, 2, 3, 1, 6, 1'b1, 1'b1);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
